// File: files.f
logic/outrun_pkg.sv
logic/cpu_bus_bridge.sv
logic/cabinet_io.sv
logic/ppi_8255.sv
logic/steer_motor.sv
logic/main_board.sv
bench/main_board_tb.sv

// File: Bender.yml
package:
  name: outrun_main_board

sources:
  - logic/outrun_pkg.sv
  - logic/cpu_bus_bridge.sv
  - logic/cabinet_io.sv
  - logic/ppi_8255.sv
  - logic/steer_motor.sv
  - logic/main_board.sv
  - target: test
    files:
      - bench/main_board_tb.sv

// File: bench/main_board_tb.sv
`timescale 1ns/1ps

module main_board_tb;

    localparam int TIMEOUT = 40;    // Cycles allowed for any single wait

    logic                  clk;
    logic                  rst;
    logic                  vint;
    outrun_pkg::axi_addr_t s_awaddr;
    logic                  s_awvalid;
    logic                  s_awready;
    outrun_pkg::axi_data_t s_wdata;
    logic [3:0]            s_wstrb;
    logic                  s_wvalid;
    logic                  s_wready;
    outrun_pkg::axi_resp_t s_bresp;
    logic                  s_bvalid;
    logic                  s_bready;
    outrun_pkg::axi_addr_t s_araddr;
    logic                  s_arvalid;
    logic                  s_arready;
    outrun_pkg::axi_data_t s_rdata;
    outrun_pkg::axi_resp_t s_rresp;
    logic                  s_rvalid;
    logic                  s_rready;
    logic                  mem_cs;
    logic                  mem_we;
    outrun_pkg::baddr_t    mem_addr;
    outrun_pkg::word_t     mem_wdata;
    logic [1:0]            mem_be;
    outrun_pkg::word_t     mem_rdata;
    logic                  mem_ok;
    logic [7:0]            joystick1;
    outrun_pkg::word_t     joyana1;
    outrun_pkg::word_t     joyana1b;
    logic [1:0]            start_button;
    logic [1:0]            coin_input;
    logic                  service;
    logic                  dip_test;
    outrun_pkg::byte_t     dipsw_a;
    outrun_pkg::byte_t     dipsw_b;
    logic                  video_en;
    logic                  snd_rstb;
    logic [1:0]            obj_cfg;
    logic                  obj_toggle;

    logic [31:0] lfsr = 32'h885b;
    logic [15:0] mem [64];         // Responder storage
    logic [15:0] ref_mem [64];     // Expected contents
    int          toggle_cnt = 0;
    logic [1:0]  resp;
    int          lat;
    logic [31:0] rdata;
    logic [5:0]  idx;
    logic [15:0] wd;
    logic [3:0]  strb;
    logic [16:0] rom_h;
    logic [7:0]  rb;
    logic [7:0]  want;
    logic [7:0]  portc;
    logic [7:0]  speed;
    logic [15:0] steer_ref;
    logic [15:0] pedal_ref;
    int          mpos;
    int          nv;

    main_board UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic logic [15:0] fill_word(int a);
        return {2'b10, 6'(a), ~6'(a), 2'b01};
    endfunction

    function automatic logic [21:0] io_addr(int sub, int rsel);
        return 22'h100000 | 22'(sub << 5) | 22'(rsel << 2);
    endfunction

    // Work RAM address with random alias bits above the 64-word window
    function automatic logic [21:0] ram_addr(logic [5:0] i);
        return {1'b0, 3'b011, 10'(rand_bits(10)), i, 2'b00};
    endfunction

    function automatic logic [7:0] adc_expect(int ch, logic [7:0] joy,
                                              logic [15:0] st, logic [15:0] pd);
        logic [7:0] scaled;
        scaled = {pd[14:8], pd[14]};
        case (ch)
            0: return !joy[0] ? 8'hD0 : (!joy[1] ? 8'h20 : st[7:0] ^ 8'h80);
            1: return !joy[3] ? 8'hF0 : (pd[15] ? ~scaled : 8'h00);    // Gas
            2: return !joy[2] ? 8'hF0 : (pd[15] ? 8'h00 : scaled);     // Brake
            default: return 8'hFF;
        endcase
    endfunction

    task automatic compare_value(string what, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail at time %0t: %s, expected %h, got %h", $time, what, expected, got);
            $display("Test FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(string what);
        $display("Timeout: no %s within %0d cycles at time %0t", what, TIMEOUT, $time);
        $display("Test FAILED");
        $fatal(1, "stopped on timeout");
    endtask

    task automatic axi_write(input logic [21:0] addr, input logic [15:0] data,
                             input logic [3:0] be, output logic [1:0] r, output int l);
        int n;
        int hold;
        @(negedge clk);
        s_awaddr  = addr;
        s_wdata   = {16'(rand_bits(16)), data};   // Upper half is ignored
        s_wstrb   = be;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        n = 0;
        #10;
        while (!s_awready) begin
            n++;
            if (n > TIMEOUT)
                report_timeout("write address handshake");
            @(negedge clk);
            #10;
        end
        compare_value("wready with awready", s_wready, 1'b1);
        @(negedge clk);
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        l = 1;
        while (!s_bvalid) begin
            l++;
            if (l > TIMEOUT)
                report_timeout("write response");
            @(negedge clk);
        end
        hold = rand_bits(2);
        repeat (hold) @(negedge clk);   // Back-pressure
        compare_value("bvalid held", s_bvalid, 1'b1);
        r = s_bresp;
        s_bready = 1'b1;
        @(negedge clk);
        s_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [21:0] addr, output logic [31:0] d,
                            output logic [1:0] r, output int l);
        int n;
        int hold;
        @(negedge clk);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        n = 0;
        #10;
        while (!s_arready) begin
            n++;
            if (n > TIMEOUT)
                report_timeout("read address handshake");
            @(negedge clk);
            #10;
        end
        @(negedge clk);
        s_arvalid = 1'b0;
        l = 1;
        while (!s_rvalid) begin
            l++;
            if (l > TIMEOUT)
                report_timeout("read response");
            @(negedge clk);
        end
        hold = rand_bits(2);
        repeat (hold) @(negedge clk);
        compare_value("rvalid held", s_rvalid, 1'b1);
        d = s_rdata;
        r = s_rresp;
        s_rready = 1'b1;
        @(negedge clk);
        s_rready = 1'b0;
    endtask

    task automatic io_write(input int sub, input int rsel, input logic [7:0] data,
                            input logic [3:0] be);
        logic [1:0] r;
        int         l;
        axi_write(io_addr(sub, rsel), {8'h00, data}, be, r, l);
        compare_value("I/O write response", r, outrun_pkg::AXI_OKAY);
        compare_value("I/O write latency", l, 2);
    endtask

    task automatic io_read(input int sub, input int rsel, output logic [7:0] data);
        logic [31:0] d;
        logic [1:0]  r;
        int          l;
        axi_read(io_addr(sub, rsel), d, r, l);
        compare_value("I/O read response", r, outrun_pkg::AXI_OKAY);
        compare_value("I/O read latency", l, 2);
        compare_value("I/O read upper half", d[31:16], 0);
        data = d[7:0];
    endtask

    // One frame: vint high for a cycle, then low for two
    task automatic frame_step(input logic [7:0] spd);
        vint = 1'b1;
        @(negedge clk);
        vint = 1'b0;
        repeat (2) @(negedge clk);
        mpos = mpos + int'($signed(spd)) * 16;
        if (mpos < int'(outrun_pkg::MOTOR_LEFT_LIM))
            mpos = outrun_pkg::MOTOR_LEFT_LIM;
        else if (mpos > int'(outrun_pkg::MOTOR_RIGHT_LIM))
            mpos = outrun_pkg::MOTOR_RIGHT_LIM;
    endtask

    task automatic motor_check();
        logic [15:0] p;
        logic [7:0]  got;
        p = 16'(mpos);
        io_read(3, 0, got);
        compare_value("motor position high byte", got, p[15:8]);
        io_read(0, 0, got);
        compare_value("port A limit sensors", got,
                      {2'b00, p == 16'hE000, p[15:8] == 8'h80, p == 16'h2000, 3'b111});
    endtask

    // Memory responder with 0 to 3 wait cycles
    initial begin : mem_responder
        int delay;
        for (int a = 0; a < 64; a++)
            mem[a] = fill_word(a);
        mem_ok    = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            mem_ok = 1'b0;
            if (mem_cs) begin
                delay = rand_bits(2);
                repeat (delay) @(negedge clk);
                if (mem_we && mem_be[0])
                    mem[mem_addr[5:0]][7:0] = mem_wdata[7:0];
                if (mem_we && mem_be[1])
                    mem[mem_addr[5:0]][15:8] = mem_wdata[15:8];
                mem_rdata = mem[mem_addr[5:0]];
                mem_ok = 1'b1;
                @(negedge clk);
                mem_ok = 1'b0;
            end
        end
    end

    always @(negedge clk)
        if (obj_toggle)
            toggle_cnt++;

    initial begin
        rst = 1'b1;
        vint = 1'b0;
        s_awaddr = '0;
        s_awvalid = 1'b0;
        s_wdata = '0;
        s_wstrb = '0;
        s_wvalid = 1'b0;
        s_bready = 1'b0;
        s_araddr = '0;
        s_arvalid = 1'b0;
        s_rready = 1'b0;
        joystick1 = 8'hFF;
        joyana1 = '0;
        joyana1b = '0;
        start_button = '0;
        coin_input = '0;
        service = 1'b0;
        dip_test = 1'b0;
        dipsw_a = '0;
        dipsw_b = '0;
        mpos = outrun_pkg::MOTOR_RESET;
        for (int a = 0; a < 64; a++)
            ref_mem[a] = fill_word(a);

        @(negedge clk);
        compare_value("outputs in reset",
                      {s_awready, s_wready, s_arready, s_bvalid, s_rvalid, mem_cs, obj_toggle},
                      7'b0);
        compare_value("control lines in reset", {video_en, snd_rstb, obj_cfg}, 4'b1100);
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // PPI after reset, motor centred
        io_read(0, 0, rb);
        compare_value("port A after reset", rb, 8'h17);
        io_read(0, 1, rb);
        compare_value("port B after reset", rb, 8'h00);
        io_read(0, 2, rb);
        compare_value("port C after reset", rb, 8'h00);
        io_read(0, 3, rb);
        compare_value("PPI control readback", rb, 8'hFF);

        // Work RAM with byte enables
        for (int i = 0; i < 40; i++) begin
            idx  = rand_bits(6);
            wd   = rand_bits(16);
            strb = rand_bits(4);
            axi_write(ram_addr(idx), wd, strb, resp, lat);
            compare_value("RAM write response", resp, outrun_pkg::AXI_OKAY);
            if (strb[0])
                ref_mem[idx][7:0] = wd[7:0];
            if (strb[1])
                ref_mem[idx][15:8] = wd[15:8];
        end
        for (int i = 0; i < 64; i++) begin
            axi_read(ram_addr(6'(i)), rdata, resp, lat);
            compare_value("RAM read response", resp, outrun_pkg::AXI_OKAY);
            compare_value($sformatf("RAM word %0d", i), rdata, {16'h0, ref_mem[i]});
        end

        // ROM writes are dropped, unmapped space decodes to an error
        for (int i = 0; i < 6; i++) begin
            rom_h = rand_bits(17);
            axi_write({3'b000, rom_h, 2'b00}, 16'(rand_bits(16)), 4'hF, resp, lat);
            compare_value("ROM write response", resp, outrun_pkg::AXI_OKAY);
            compare_value("ROM write latency", lat, 2);
            axi_read(ram_addr(rom_h[5:0]), rdata, resp, lat);
            compare_value("RAM after ROM write", rdata, {16'h0, ref_mem[rom_h[5:0]]});
            axi_read({1'b1, 21'(rand_bits(21))}, rdata, resp, lat);
            compare_value("high unmapped read response", resp, outrun_pkg::AXI_DECERR);
            compare_value("unmapped read latency", lat, 2);
            axi_read({5'b01001, 15'(rand_bits(15)), 2'b00}, rdata, resp, lat);
            compare_value("unmapped read response", resp, outrun_pkg::AXI_DECERR);
            axi_write({5'b01001, 15'(rand_bits(15)), 2'b00}, 16'h1234, 4'h3, resp, lat);
            compare_value("unmapped write response", resp, outrun_pkg::AXI_DECERR);
        end

        // Switch ports
        for (int i = 0; i < 8; i++) begin
            joystick1    = rand_bits(8);
            coin_input   = rand_bits(2);
            start_button = rand_bits(2);
            service      = rand_bits(1);
            dip_test     = rand_bits(1);
            dipsw_a      = rand_bits(8);
            dipsw_b      = rand_bits(8);
            io_read(1, 0, rb);
            compare_value("switch port 0", rb, {coin_input, ~joystick1[4], joystick1[4],
                                                start_button[0], service, dip_test, 1'b1});
            io_read(1, 1, rb);
            compare_value("switch port 1", rb, 8'hFF);
            io_read(1, 2, rb);
            compare_value("DIP switch A", rb, dipsw_a);
            io_read(1, 3, rb);
            compare_value("DIP switch B", rb, dipsw_b);
        end

        // ADC latch, channel select through port C
        for (int i = 0; i < 12; i++) begin
            // Second half releases the override buttons so the analog path is read
            joystick1 = rand_bits(8) | ((i < 6) ? 8'h00 : 8'h0F);
            steer_ref = rand_bits(16);
            pedal_ref = rand_bits(16);
            joyana1   = steer_ref;
            joyana1b  = pedal_ref;
            io_write(3, 0, 8'(rand_bits(8)), 4'h1);
            joyana1  = rand_bits(16);    // Must not reach the latched value
            joyana1b = rand_bits(16);
            portc = {3'(rand_bits(3)), 3'(i % 3), 2'(rand_bits(2))};
            io_write(0, 2, portc, 4'h1);
            compare_value("video_en from port C", video_en, portc[5]);
            compare_value("snd_rstb from port C", snd_rstb, portc[0]);
            compare_value("obj_cfg from port C", obj_cfg, portc[7:6]);
            io_read(3, 0, rb);
            want = adc_expect(i % 3, joystick1, steer_ref, pedal_ref);
            compare_value($sformatf("ADC channel %0d", i % 3), rb, want);
        end

        // Steering motor on channel 3
        io_write(0, 2, 8'b0010_1101, 4'h1);
        for (int i = 0; i < 7; i++) begin
            speed = (i == 6) ? 8'h80 : 8'(rand_bits(8));
            nv    = (i == 6) ? 20 : int'(rand_bits(4)) + 1;
            io_write(0, 1, speed, 4'h1);
            io_read(0, 1, rb);
            compare_value("port B readback", rb, speed);
            repeat (nv) frame_step(speed);
            motor_check();
        end

        // Object toggle strobe
        nv = toggle_cnt;
        io_write(7, int'(rand_bits(2)), 8'(rand_bits(8)), 4'h1);
        repeat (3) @(negedge clk);
        compare_value("obj_toggle pulses", toggle_cnt - nv, 1);
        io_write(7, 0, 8'h00, 4'h2);    // Low byte not enabled
        repeat (3) @(negedge clk);
        compare_value("obj_toggle without low byte", toggle_cnt - nv, 1);

        $display("Test OK");
        $finish;
    end

endmodule

// File: logic/main_board.sv
`timescale 1ns/1ps

module main_board (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  vint,
    // AXI4-Lite host
    input  outrun_pkg::axi_addr_t s_awaddr,
    input  logic                  s_awvalid,
    output logic                  s_awready,
    input  outrun_pkg::axi_data_t s_wdata,
    input  logic [3:0]            s_wstrb,
    input  logic                  s_wvalid,
    output logic                  s_wready,
    output outrun_pkg::axi_resp_t s_bresp,
    output logic                  s_bvalid,
    input  logic                  s_bready,
    input  outrun_pkg::axi_addr_t s_araddr,
    input  logic                  s_arvalid,
    output logic                  s_arready,
    output outrun_pkg::axi_data_t s_rdata,
    output outrun_pkg::axi_resp_t s_rresp,
    output logic                  s_rvalid,
    input  logic                  s_rready,
    // ROM and work RAM
    output logic                  mem_cs,
    output logic                  mem_we,
    output outrun_pkg::baddr_t    mem_addr,
    output outrun_pkg::word_t     mem_wdata,
    output logic [1:0]            mem_be,
    input  outrun_pkg::word_t     mem_rdata,
    input  logic                  mem_ok,
    // Cabinet
    input  logic [7:0]            joystick1,
    input  outrun_pkg::word_t     joyana1,
    input  outrun_pkg::word_t     joyana1b,
    input  logic [1:0]            start_button,
    input  logic [1:0]            coin_input,
    input  logic                  service,
    input  logic                  dip_test,
    input  outrun_pkg::byte_t     dipsw_a,
    input  outrun_pkg::byte_t     dipsw_b,
    output logic                  video_en,
    output logic                  snd_rstb,
    output logic [1:0]            obj_cfg,
    output logic                  obj_toggle
);

    logic                   io_cs;
    logic                   io_we;
    outrun_pkg::io_sub_t    io_sub;
    logic [1:0]             io_reg;
    outrun_pkg::byte_t      io_wdata;
    outrun_pkg::byte_t      cab_rdata;
    outrun_pkg::byte_t      bus_rdata;
    logic                   ppi_cs;
    outrun_pkg::byte_t      ppi_rdata;
    outrun_pkg::byte_t      ppi_portb;
    outrun_pkg::byte_t      ppi_portc;
    outrun_pkg::motor_pos_t motor_pos;
    logic [2:0]             motor_lim;

    // I/O data bus idles high between cycles
    assign bus_rdata = io_cs ? cab_rdata : outrun_pkg::IDLE_BYTE;

    cpu_bus_bridge u_bridge (
        .clk       (clk),
        .rst       (rst),
        .s_awaddr  (s_awaddr),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_wdata   (s_wdata),
        .s_wstrb   (s_wstrb),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_bresp   (s_bresp),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .mem_cs    (mem_cs),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_be    (mem_be),
        .mem_rdata (mem_rdata),
        .mem_ok    (mem_ok),
        .io_cs     (io_cs),
        .io_we     (io_we),
        .io_sub    (io_sub),
        .io_reg    (io_reg),
        .io_wdata  (io_wdata),
        .io_rdata  (bus_rdata)
    );

    cabinet_io u_cabinet (
        .clk          (clk),
        .rst          (rst),
        .io_cs        (io_cs),
        .io_we        (io_we),
        .io_sub       (io_sub),
        .io_reg       (io_reg),
        .io_wdata     (io_wdata),
        .io_rdata     (cab_rdata),
        .ppi_rdata    (ppi_rdata),
        .ppi_portc    (ppi_portc),
        .ppi_cs       (ppi_cs),
        .motor_pos    (motor_pos),
        .joystick1    (joystick1),
        .joyana1      (joyana1),
        .joyana1b     (joyana1b),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .obj_toggle   (obj_toggle),
        .video_en     (video_en),
        .snd_rstb     (snd_rstb),
        .obj_cfg      (obj_cfg)
    );

    ppi_8255 u_ppi (
        .clk       (clk),
        .rst       (rst),
        .cs        (ppi_cs),
        .we        (io_we),
        .port_sel  (io_reg),
        .wdata     (io_wdata),
        .porta_in  ({2'b00, motor_lim, 3'b111}),  // Motor limit sensors
        .rdata     (ppi_rdata),
        .portb_out (ppi_portb),
        .portc_out (ppi_portc)
    );

    steer_motor u_motor (
        .clk    (clk),
        .rst    (rst),
        .vint   (vint),
        .speed  (ppi_portb),
        .pos    (motor_pos),
        .limits (motor_lim)
    );

endmodule

// File: logic/steer_motor.sv
`timescale 1ns/1ps

module steer_motor (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   vint,
    input  outrun_pkg::byte_t      speed,
    output outrun_pkg::motor_pos_t pos,
    output logic [2:0]             limits
);

    logic               vint_q;
    logic               frame;
    logic signed [17:0] step;
    logic signed [17:0] next_pos;

    assign frame = vint && !vint_q;

    // Speed is two's complement, scaled up per frame
    assign step     = 18'(signed'(speed)) <<< outrun_pkg::MOTOR_SHIFT;
    assign next_pos = signed'({2'b00, pos}) + step;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vint_q <= 1'b0;
            pos    <= outrun_pkg::MOTOR_RESET;
        end else begin
            vint_q <= vint;
            if (frame) begin
                if (next_pos < signed'({2'b00, outrun_pkg::MOTOR_LEFT_LIM}))
                    pos <= outrun_pkg::MOTOR_LEFT_LIM;
                else if (next_pos > signed'({2'b00, outrun_pkg::MOTOR_RIGHT_LIM}))
                    pos <= outrun_pkg::MOTOR_RIGHT_LIM;
                else
                    pos <= next_pos[15:0];
            end
        end
    end

    assign limits = {pos == outrun_pkg::MOTOR_RIGHT_LIM,
                     pos[15:8] == 8'h80,               // Centre sensor
                     pos == outrun_pkg::MOTOR_LEFT_LIM};

    a_pos_range: assert property (@(posedge clk) disable iff (rst)
        pos >= outrun_pkg::MOTOR_LEFT_LIM && pos <= outrun_pkg::MOTOR_RIGHT_LIM);

endmodule

// File: logic/ppi_8255.sv
`timescale 1ns/1ps

module ppi_8255 (
    input  logic              clk,
    input  logic              rst,
    input  logic              cs,
    input  logic              we,
    input  logic [1:0]        port_sel,
    input  outrun_pkg::byte_t wdata,
    input  outrun_pkg::byte_t porta_in,
    output outrun_pkg::byte_t rdata,
    output outrun_pkg::byte_t portb_out,
    output outrun_pkg::byte_t portc_out
);

    // Fixed mode 0, A in and B, C out
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            portb_out <= 8'h00;
            portc_out <= 8'h00;
        end else if (cs && we) begin
            case (port_sel)
                2'd1: portb_out <= wdata;
                2'd2: portc_out <= wdata;
                default: ;  // Port A has no latch, control word has no effect
            endcase
        end
    end

    always_comb begin
        case (port_sel)
            2'd0: rdata = porta_in;   // Pins, not a latch
            2'd1: rdata = portb_out;
            2'd2: rdata = portc_out;
            default: rdata = 8'hFF;
        endcase
    end

endmodule

// File: logic/cabinet_io.sv
`timescale 1ns/1ps

module cabinet_io (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   io_cs,
    input  logic                   io_we,
    input  outrun_pkg::io_sub_t    io_sub,
    input  logic [1:0]             io_reg,
    input  outrun_pkg::byte_t      io_wdata,
    output outrun_pkg::byte_t      io_rdata,
    input  outrun_pkg::byte_t      ppi_rdata,
    input  outrun_pkg::byte_t      ppi_portc,
    output logic                   ppi_cs,
    input  outrun_pkg::motor_pos_t motor_pos,
    input  logic [7:0]             joystick1,
    input  outrun_pkg::word_t      joyana1,
    input  outrun_pkg::word_t      joyana1b,
    input  logic [1:0]             start_button,
    input  logic [1:0]             coin_input,
    input  logic                   service,
    input  logic                   dip_test,
    input  outrun_pkg::byte_t      dipsw_a,
    input  outrun_pkg::byte_t      dipsw_b,
    output logic                   obj_toggle,
    output logic                   video_en,
    output logic                   snd_rstb,
    output logic [1:0]             obj_cfg
);

    logic [2:0]        adc_ch;
    outrun_pkg::word_t steer;      // Wheel sample
    outrun_pkg::word_t pedal;      // Gas in the top half, brake below the sign
    outrun_pkg::byte_t adc_byte;
    outrun_pkg::byte_t sw_byte;
    logic              adc_wr;

    assign ppi_cs     = io_cs && io_sub == outrun_pkg::IO_PPI;
    assign adc_wr     = io_cs && io_we && io_sub == outrun_pkg::IO_ADC;
    assign obj_toggle = io_cs && io_we && io_sub == outrun_pkg::IO_OBJ_TOGGLE;

    // Any write to the ADC starts a conversion
    always_ff @(posedge clk) begin
        if (adc_wr) begin
            steer <= joyana1;
            pedal <= joyana1b;
        end
    end

    // Control lines hang off PPI port C
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            adc_ch   <= 3'd0;
            video_en <= 1'b1;
            snd_rstb <= 1'b1;
            obj_cfg  <= 2'd0;
        end else begin
            obj_cfg  <= ppi_portc[7:6];  // Object engine and colour mixer
            video_en <= ppi_portc[5];
            adc_ch   <= ppi_portc[4:2];
            snd_rstb <= ppi_portc[0];
        end
    end

    always_comb begin
        case (adc_ch)
            3'd0: adc_byte = !joystick1[0] ? 8'hD0 :
                             !joystick1[1] ? 8'h20 : steer[7:0] ^ 8'h80;
            3'd1: adc_byte = !joystick1[3] ? 8'hF0 :
                             pedal[15] ? ~{pedal[14:8], pedal[14]} : 8'h00;  // Gas
            3'd2: adc_byte = !joystick1[2] ? 8'hF0 :
                             pedal[15] ? 8'h00 : {pedal[14:8], pedal[14]};   // Brake
            3'd3: adc_byte = motor_pos[15:8];
            default: adc_byte = 8'hFF;
        endcase
    end

    always_comb begin
        case (io_reg)
            2'd0: sw_byte = {coin_input, ~joystick1[4], joystick1[4],
                             start_button[0], service, dip_test, 1'b1};
            2'd1: sw_byte = 8'hFF;
            2'd2: sw_byte = dipsw_a;
            default: sw_byte = dipsw_b;
        endcase
    end

    always_comb begin
        case (io_sub)
            outrun_pkg::IO_PPI:    io_rdata = ppi_rdata;
            outrun_pkg::IO_SWITCH: io_rdata = sw_byte;
            outrun_pkg::IO_ADC:    io_rdata = adc_byte;
            default:               io_rdata = outrun_pkg::IDLE_BYTE;
        endcase
    end

endmodule

// File: logic/cpu_bus_bridge.sv
`timescale 1ns/1ps

module cpu_bus_bridge (
    input  logic                  clk,
    input  logic                  rst,
    // AXI4-Lite slave
    input  outrun_pkg::axi_addr_t s_awaddr,
    input  logic                  s_awvalid,
    output logic                  s_awready,
    input  outrun_pkg::axi_data_t s_wdata,
    input  logic [3:0]            s_wstrb,
    input  logic                  s_wvalid,
    output logic                  s_wready,
    output outrun_pkg::axi_resp_t s_bresp,
    output logic                  s_bvalid,
    input  logic                  s_bready,
    input  outrun_pkg::axi_addr_t s_araddr,
    input  logic                  s_arvalid,
    output logic                  s_arready,
    output outrun_pkg::axi_data_t s_rdata,
    output outrun_pkg::axi_resp_t s_rresp,
    output logic                  s_rvalid,
    input  logic                  s_rready,
    // ROM and work RAM
    output logic                  mem_cs,
    output logic                  mem_we,
    output outrun_pkg::baddr_t    mem_addr,
    output outrun_pkg::word_t     mem_wdata,
    output logic [1:0]            mem_be,
    input  outrun_pkg::word_t     mem_rdata,
    input  logic                  mem_ok,
    // Cabinet I/O
    output logic                  io_cs,
    output logic                  io_we,
    output outrun_pkg::io_sub_t   io_sub,
    output logic [1:0]            io_reg,
    output outrun_pkg::byte_t     io_wdata,
    input  outrun_pkg::byte_t     io_rdata
);

    outrun_pkg::bridge_state_e state;
    outrun_pkg::axi_addr_t     acc_addr;
    outrun_pkg::baddr_t        haddr;
    logic                      wr_go;
    logic                      rd_go;
    logic                      unmapped;
    logic                      in_rom;
    logic                      in_io;

    // Captured access
    outrun_pkg::baddr_t    addr_q;
    outrun_pkg::word_t     wdata_q;
    logic [1:0]            be_q;
    logic                  we_q;
    logic                  is_io_q;
    outrun_pkg::axi_resp_t resp_q;
    outrun_pkg::word_t     rdata_q;

    // Writes win when both channels present
    assign wr_go = state == outrun_pkg::IDLE && s_awvalid && s_wvalid;
    assign rd_go = state == outrun_pkg::IDLE && s_arvalid && !s_awvalid && !s_wvalid;

    assign s_awready = wr_go;
    assign s_wready  = wr_go;
    assign s_arready = rd_go;

    // Decode straight off the bus in the accept cycle
    assign acc_addr = wr_go ? s_awaddr : s_araddr;
    assign haddr    = acc_addr[20:2];
    assign unmapped = acc_addr[21] || haddr >= outrun_pkg::IO_TOP;
    assign in_rom   = haddr < outrun_pkg::ROM_TOP;
    assign in_io    = haddr >= outrun_pkg::RAM_TOP;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= outrun_pkg::IDLE;
        end else begin
            case (state)
                outrun_pkg::IDLE: begin
                    // ROM writes and unmapped accesses share the single-cycle path
                    if (wr_go || rd_go) begin
                        if (unmapped || in_io || (in_rom && wr_go))
                            state <= outrun_pkg::IO_ACCESS;
                        else
                            state <= outrun_pkg::MEM_WAIT;
                    end
                end
                outrun_pkg::MEM_WAIT: begin
                    if (mem_ok)
                        state <= outrun_pkg::RESP;
                end
                outrun_pkg::IO_ACCESS: state <= outrun_pkg::RESP;
                outrun_pkg::RESP: begin
                    if ((we_q && s_bready) || (!we_q && s_rready))
                        state <= outrun_pkg::IDLE;
                end
                default: state <= outrun_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go || rd_go) begin
            addr_q  <= haddr;
            wdata_q <= s_wdata[15:0];
            be_q    <= wr_go ? s_wstrb[1:0] : 2'b11;  // Reads take both bytes
            we_q    <= wr_go;
            is_io_q <= in_io && !unmapped;
            resp_q  <= unmapped ? outrun_pkg::AXI_DECERR : outrun_pkg::AXI_OKAY;
        end
        if (state == outrun_pkg::MEM_WAIT && mem_ok)
            rdata_q <= mem_rdata;
        if (state == outrun_pkg::IO_ACCESS)
            rdata_q <= is_io_q ? {8'hFF, io_rdata} : 16'h0000;  // Upper byte floats high
    end

    assign mem_cs    = state == outrun_pkg::MEM_WAIT;
    assign mem_we    = we_q;
    assign mem_addr  = addr_q;
    assign mem_wdata = wdata_q;
    assign mem_be    = be_q;

    assign io_cs    = state == outrun_pkg::IO_ACCESS && is_io_q;
    assign io_we    = io_cs && we_q && be_q[0];   // I/O sits on the low byte
    assign io_sub   = addr_q[5:3];
    assign io_reg   = addr_q[1:0];
    assign io_wdata = wdata_q[7:0];

    assign s_bvalid = state == outrun_pkg::RESP && we_q;
    assign s_rvalid = state == outrun_pkg::RESP && !we_q;
    assign s_bresp  = resp_q;
    assign s_rresp  = resp_q;
    assign s_rdata  = {16'h0000, rdata_q};

    a_cs_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_cs && io_cs));

    // Memory side may stall for any number of cycles
    a_mem_stable: assert property (@(posedge clk) disable iff (rst)
        mem_cs && !mem_ok |=> mem_cs && $stable({mem_we, mem_addr, mem_wdata, mem_be}));

endmodule

// File: logic/outrun_pkg.sv
package outrun_pkg;

    // AXI4-Lite host side
    localparam int AXI_AW = 22;
    localparam int AXI_DW = 32;

    typedef logic [AXI_AW-1:0] axi_addr_t;
    typedef logic [AXI_DW-1:0] axi_data_t;
    typedef logic [1:0]        axi_resp_t;

    // Board bus
    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [18:0] baddr_t;      // Address bits 19 to 1
    typedef logic [2:0]  io_sub_t;
    typedef logic [15:0] motor_pos_t;

    typedef enum logic [1:0] {
        IDLE,
        MEM_WAIT,
        IO_ACCESS,
        RESP
    } bridge_state_e;

    localparam axi_resp_t AXI_OKAY   = 2'b00;
    localparam axi_resp_t AXI_DECERR = 2'b11;

    // Region tops as halfword addresses
    localparam baddr_t ROM_TOP = 19'h30000;   // Work RAM at byte 0x60000
    localparam baddr_t RAM_TOP = 19'h40000;   // I/O at byte 0x80000
    localparam baddr_t IO_TOP  = 19'h48000;   // Unmapped from byte 0x90000

    // I/O sub-regions, byte address bits 6 to 4
    localparam io_sub_t IO_PPI        = 3'd0;
    localparam io_sub_t IO_SWITCH     = 3'd1;
    localparam io_sub_t IO_ADC        = 3'd3;
    localparam io_sub_t IO_OBJ_TOGGLE = 3'd7;

    localparam motor_pos_t MOTOR_RESET     = 16'h8000;
    localparam motor_pos_t MOTOR_LEFT_LIM  = 16'h2000;
    localparam motor_pos_t MOTOR_RIGHT_LIM = 16'hE000;
    localparam int         MOTOR_SHIFT     = 4;

    localparam byte_t IDLE_BYTE = 8'hFF;

endpackage
